// File: dct_pkg.sv
// Shared widths, enums and bus structs for the 8-point Loeffler DCT.
// Samples are signed Q8 in 16 bits, and all arithmetic wraps at 16 bits.
// The microprogram is tied to these values, so they are not parameters.
package dct_pkg;

    localparam int DATA_W    = 16;
    localparam int FRAC_W    = 8;
    localparam int COEFF_W   = 9;   // unsigned Q8 coefficient
    localparam int SPAD_AW   = 5;   // 32 scratchpad entries
    localparam int IDX_W     = 3;
    localparam int UCODE_LEN = 46;
    localparam int PC_W      = 6;

    typedef logic signed [DATA_W-1:0] data_t;

    // where a word's read fields point
    typedef enum logic {
        READ_FETCH,
        READ_SPAD
    } read_src_e;

    // operand latch load source and adder second operand source
    typedef enum logic {
        SRC_MEM,    // operand bus
        SRC_MUL     // registered multiplier output
    } op_src_e;

    typedef enum logic {
        DEST_SPAD,
        DEST_OUT
    } write_dest_e;

    typedef enum logic {
        WSRC_ADDER,
        WSRC_MUL
    } write_src_e;

    // Q8 values are in dct_multiplier
    typedef enum logic [2:0] {
        C3_COS,
        C3_SIN,
        C1_COS,
        C1_SIN,
        R2C6_COS,
        R2C6_SIN,
        SQRT2,
        SQRT2_4
    } coeff_e;

    typedef struct packed {
        logic [SPAD_AW-1:0] read_addr;
        read_src_e          read_src;
        logic               latch_op1;
        op_src_e            op1_src;
        logic               neg_op1;
        logic               neg_op2;
        op_src_e            op2_src;
        coeff_e             coeff;
        logic               write_en;
        write_dest_e        write_dest;
        write_src_e         write_src;
        logic [SPAD_AW-1:0] write_addr;
    } ucode_word_t;

    typedef struct packed {
        logic [IDX_W-1:0] index;
        data_t            value;
    } result_t;

endpackage

// File: dct_multiplier.sv
// Coefficient table and one-stage registered Q8 multiplier.
// The product is shifted right by FRAC_W and wraps to DATA_W bits.
module dct_multiplier (
    input  logic             clock,
    input  logic             nreset,
    input  dct_pkg::data_t   operand,
    input  dct_pkg::coeff_e  coeff,
    output dct_pkg::data_t   product
);

    logic [dct_pkg::COEFF_W-1:0]                   kval;
    logic signed [dct_pkg::DATA_W+dct_pkg::COEFF_W:0] full;

    always_comb begin
        case (coeff)
            dct_pkg::C3_COS:   kval = 9'd213;
            dct_pkg::C3_SIN:   kval = 9'd142;
            dct_pkg::C1_COS:   kval = 9'd251;
            dct_pkg::C1_SIN:   kval = 9'd50;
            dct_pkg::R2C6_COS: kval = 9'd139;
            dct_pkg::R2C6_SIN: kval = 9'd334;
            dct_pkg::SQRT2:    kval = 9'd362;
            default:           kval = 9'd91;   // sqrt2 / 4
        endcase
    end

    // coefficient is zero-extended so it stays positive
    assign full = operand * $signed({1'b0, kval});

    always_ff @(posedge clock) begin
        if (nreset) begin
            product <= '0;
        end else begin
            product <= full[dct_pkg::FRAC_W +: dct_pkg::DATA_W];
        end
    end

endmodule

// File: dct_scratchpad.sv
// 32-entry register file, one synchronous read port and one write port.
// A read of the address being written returns the new data.
// Contents are not cleared, the microprogram writes each entry before use.
module dct_scratchpad (
    input  logic                        clock,
    input  logic [dct_pkg::SPAD_AW-1:0] read_addr,
    input  logic [dct_pkg::SPAD_AW-1:0] write_addr,
    input  logic                        write_en,
    input  dct_pkg::data_t              write_data,
    output dct_pkg::data_t              read_data
);

    dct_pkg::data_t mem [2**dct_pkg::SPAD_AW];

    always_ff @(posedge clock) begin
        if (write_en) mem[write_addr] <= write_data;
        if (write_en && (write_addr == read_addr)) begin
            read_data <= write_data;   // write-first
        end else begin
            read_data <= mem[read_addr];
        end
    end

endmodule

// File: dct_sequencer.sv
// Start/busy/done control and the microcode ROM of the DCT.
// A start seen while busy is ignored. Outside a run the word is inert.
// Read fields fetch for the next cycle, all other fields act on this cycle's bus.
module dct_sequencer (
    input  logic                 clock,
    input  logic                 nreset,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output dct_pkg::ucode_word_t uword
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_e;

    // latch load source
    typedef enum logic [1:0] {
        LAT_NO,
        LAT_BUS,
        LAT_MUL
    } lat_e;

    // adder form and write source, *_P takes the product as second operand
    typedef enum logic [2:0] {
        NOP,
        ADD,
        SUB,
        RSUB,
        ADD_P,
        SUB_P,
        RSUB_P,
        PROD
    } alu_e;

    state_e                state;
    logic [dct_pkg::PC_W-1:0] pc;
    dct_pkg::ucode_word_t  rom_word;

    function automatic dct_pkg::ucode_word_t mk(input logic spad, input logic [4:0] raddr,
                                                input lat_e lat, input alu_e alu,
                                                input dct_pkg::coeff_e c, input logic out,
                                                input logic [4:0] waddr);
        dct_pkg::ucode_word_t u;
        u            = '0;
        u.read_src   = spad ? dct_pkg::READ_SPAD : dct_pkg::READ_FETCH;
        u.read_addr  = raddr;
        u.latch_op1  = (lat != LAT_NO);
        u.op1_src    = (lat == LAT_MUL) ? dct_pkg::SRC_MUL : dct_pkg::SRC_MEM;
        u.neg_op1    = (alu inside {RSUB, RSUB_P});
        u.neg_op2    = (alu inside {SUB, SUB_P});
        u.op2_src    = (alu inside {ADD_P, SUB_P, RSUB_P}) ? dct_pkg::SRC_MUL : dct_pkg::SRC_MEM;
        u.coeff      = c;
        u.write_en   = (alu != NOP);
        u.write_dest = out ? dct_pkg::DEST_OUT : dct_pkg::DEST_SPAD;
        u.write_src  = (alu == PROD) ? dct_pkg::WSRC_MUL : dct_pkg::WSRC_ADDER;
        u.write_addr = waddr;
        return u;
    endfunction

    always_comb begin
        case (pc)
            // stage 1, sums and differences of input pairs
            6'd0:  rom_word = mk(1'b0, 5'd0, LAT_NO, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd1:  rom_word = mk(1'b0, 5'd7, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd2:  rom_word = mk(1'b0, 5'd7, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd3:  rom_word = mk(1'b0, 5'd1, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd7);
            6'd4:  rom_word = mk(1'b0, 5'd6, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd5:  rom_word = mk(1'b0, 5'd6, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd1);
            6'd6:  rom_word = mk(1'b0, 5'd2, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd6);
            6'd7:  rom_word = mk(1'b0, 5'd5, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd8:  rom_word = mk(1'b0, 5'd5, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd2);
            6'd9:  rom_word = mk(1'b0, 5'd3, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd5);
            6'd10: rom_word = mk(1'b0, 5'd4, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd11: rom_word = mk(1'b0, 5'd4, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd3);
            6'd12: rom_word = mk(1'b1, 5'd0, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd4);
            // even part, s8 s11 s9 s10
            6'd13: rom_word = mk(1'b1, 5'd3, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd14: rom_word = mk(1'b1, 5'd3, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd8);
            6'd15: rom_word = mk(1'b1, 5'd1, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd11);
            6'd16: rom_word = mk(1'b1, 5'd2, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd17: rom_word = mk(1'b1, 5'd2, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd9);
            6'd18: rom_word = mk(1'b1, 5'd4, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd10);
            // odd rotations, products land one word after their operand
            6'd19: rom_word = mk(1'b1, 5'd7, LAT_NO, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd20: rom_word = mk(1'b1, 5'd4, LAT_MUL, NOP, dct_pkg::C3_SIN, 1'b0, 5'd0);
            6'd21: rom_word = mk(1'b1, 5'd7, LAT_NO, ADD_P, dct_pkg::C3_SIN, 1'b0, 5'd12);
            6'd22: rom_word = mk(1'b1, 5'd5, LAT_MUL, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd23: rom_word = mk(1'b1, 5'd6, LAT_NO, RSUB_P, dct_pkg::C1_COS, 1'b0, 5'd15);
            6'd24: rom_word = mk(1'b1, 5'd5, LAT_MUL, NOP, dct_pkg::C1_SIN, 1'b0, 5'd0);
            6'd25: rom_word = mk(1'b1, 5'd6, LAT_NO, ADD_P, dct_pkg::C1_SIN, 1'b0, 5'd13);
            6'd26: rom_word = mk(1'b1, 5'd8, LAT_MUL, NOP, dct_pkg::C1_COS, 1'b0, 5'd0);
            6'd27: rom_word = mk(1'b1, 5'd9, LAT_NO, RSUB_P, dct_pkg::SQRT2_4, 1'b0, 5'd14);
            // even outputs y0 y4 y2 y6
            6'd28: rom_word = mk(1'b1, 5'd8, LAT_MUL, NOP, dct_pkg::SQRT2_4, 1'b0, 5'd0);
            6'd29: rom_word = mk(1'b1, 5'd10, LAT_MUL, ADD_P, dct_pkg::SQRT2_4, 1'b1, 5'd0);
            6'd30: rom_word = mk(1'b1, 5'd11, LAT_NO, RSUB_P, dct_pkg::R2C6_COS, 1'b1, 5'd4);
            6'd31: rom_word = mk(1'b1, 5'd10, LAT_MUL, NOP, dct_pkg::R2C6_SIN, 1'b0, 5'd0);
            6'd32: rom_word = mk(1'b1, 5'd11, LAT_NO, ADD_P, dct_pkg::R2C6_SIN, 1'b1, 5'd2);
            6'd33: rom_word = mk(1'b1, 5'd12, LAT_MUL, NOP, dct_pkg::R2C6_COS, 1'b0, 5'd0);
            6'd34: rom_word = mk(1'b1, 5'd14, LAT_BUS, RSUB_P, dct_pkg::C3_COS, 1'b1, 5'd6);
            // odd sums s20 s22 s23 s21
            6'd35: rom_word = mk(1'b1, 5'd14, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd20);
            6'd36: rom_word = mk(1'b1, 5'd13, LAT_NO, SUB, dct_pkg::C3_COS, 1'b0, 5'd22);
            6'd37: rom_word = mk(1'b1, 5'd15, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd38: rom_word = mk(1'b1, 5'd15, LAT_NO, ADD, dct_pkg::C3_COS, 1'b0, 5'd23);
            6'd39: rom_word = mk(1'b1, 5'd20, LAT_NO, RSUB, dct_pkg::C3_COS, 1'b0, 5'd21);
            // odd outputs y1 y7 y3 y5
            6'd40: rom_word = mk(1'b1, 5'd23, LAT_BUS, NOP, dct_pkg::C3_COS, 1'b0, 5'd0);
            6'd41: rom_word = mk(1'b1, 5'd23, LAT_NO, ADD, dct_pkg::C3_COS, 1'b1, 5'd1);
            6'd42: rom_word = mk(1'b1, 5'd21, LAT_NO, RSUB, dct_pkg::C3_COS, 1'b1, 5'd7);
            6'd43: rom_word = mk(1'b1, 5'd22, LAT_NO, NOP, dct_pkg::SQRT2, 1'b0, 5'd0);
            6'd44: rom_word = mk(1'b1, 5'd0, LAT_NO, PROD, dct_pkg::SQRT2, 1'b1, 5'd3);
            6'd45: rom_word = mk(1'b1, 5'd0, LAT_NO, PROD, dct_pkg::C3_COS, 1'b1, 5'd5);
            default: rom_word = '0;
        endcase
    end

    assign busy  = (state == ST_RUN);
    assign uword = busy ? rom_word : '0;   // inert while idle

    always_ff @(posedge clock) begin
        if (nreset) begin
            state <= ST_IDLE;
            pc    <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == ST_IDLE) begin
                pc <= '0;
                if (start) state <= ST_RUN;
            end else if (pc == dct_pkg::PC_W'(dct_pkg::UCODE_LEN - 1)) begin
                state <= ST_IDLE;   // done and falling busy share a cycle
                done  <= 1'b1;
                pc    <= '0;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

// File: dct_datapath.sv
// Operand bus, operand latch, add/negate unit and write routing.
// Combinational from the operand bus to the write outputs. The operand
// latch and the registered bus source are the only state here.
module dct_datapath (
    input  logic                        clock,
    input  logic                        nreset,
    input  dct_pkg::ucode_word_t        uword,
    input  dct_pkg::data_t              fetch_data,
    input  dct_pkg::data_t              spad_data,
    input  dct_pkg::data_t              product,
    output dct_pkg::data_t              op_bus,
    output logic                        spad_wen,
    output logic [dct_pkg::SPAD_AW-1:0] spad_waddr,
    output dct_pkg::data_t              wdata,
    output logic                        result_valid,
    output dct_pkg::result_t            result
);

    dct_pkg::read_src_e bus_src;   // source picked by the previous word
    dct_pkg::data_t     op_latch;
    dct_pkg::data_t     op2;
    dct_pkg::data_t     term1;
    dct_pkg::data_t     term2;
    dct_pkg::data_t     sum;

    // the bus carries what the previous word read
    assign op_bus = (bus_src == dct_pkg::READ_SPAD) ? spad_data : fetch_data;

    always_ff @(posedge clock) begin
        if (nreset) begin
            bus_src  <= dct_pkg::READ_FETCH;
            op_latch <= '0;
        end else begin
            bus_src <= uword.read_src;
            if (uword.latch_op1) begin
                op_latch <= (uword.op1_src == dct_pkg::SRC_MUL) ? product : op_bus;
            end
        end
    end

    assign op2   = (uword.op2_src == dct_pkg::SRC_MUL) ? product : op_bus;
    assign term1 = uword.neg_op1 ? -op_latch : op_latch;
    assign term2 = uword.neg_op2 ? -op2 : op2;
    assign sum   = term1 + term2;   // wraps at 16 bits

    assign wdata = (uword.write_src == dct_pkg::WSRC_MUL) ? product : sum;

    // route the write
    assign spad_wen     = uword.write_en && (uword.write_dest == dct_pkg::DEST_SPAD);
    assign spad_waddr   = uword.write_addr;
    assign result_valid = uword.write_en && (uword.write_dest == dct_pkg::DEST_OUT);
    assign result.index = uword.write_addr[dct_pkg::IDX_W-1:0];
    assign result.value = wdata;

endmodule

// File: loeffler_dct8.sv
// 8-point Loeffler DCT, microcoded, on signed Q8 samples.
// The input buffer must return fetch_data one cycle after fetch_addr.
// No back-pressure, every result strobe must be taken.
module loeffler_dct8 (
    input  logic                      clock,
    input  logic                      nreset,
    input  logic                      start,
    output logic                      busy,
    output logic                      done,
    output logic [dct_pkg::IDX_W-1:0] fetch_addr,
    input  dct_pkg::data_t            fetch_data,
    output logic                      result_valid,
    output dct_pkg::result_t          result
);

    dct_pkg::ucode_word_t        uword;
    dct_pkg::data_t              op_bus;
    dct_pkg::data_t              product;
    dct_pkg::data_t              spad_rdata;
    dct_pkg::data_t              wdata;
    logic                        spad_wen;
    logic [dct_pkg::SPAD_AW-1:0] spad_waddr;

    assign fetch_addr = uword.read_addr[dct_pkg::IDX_W-1:0];

    dct_sequencer u_seq (
        .clock  (clock),
        .nreset (nreset),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .uword  (uword)
    );

    dct_datapath u_dp (
        .clock        (clock),
        .nreset       (nreset),
        .uword        (uword),
        .fetch_data   (fetch_data),
        .spad_data    (spad_rdata),
        .product      (product),
        .op_bus       (op_bus),
        .spad_wen     (spad_wen),
        .spad_waddr   (spad_waddr),
        .wdata        (wdata),
        .result_valid (result_valid),
        .result       (result)
    );

    dct_multiplier u_mul (
        .clock   (clock),
        .nreset  (nreset),
        .operand (op_bus),
        .coeff   (uword.coeff),
        .product (product)
    );

    dct_scratchpad u_spad (
        .clock      (clock),
        .read_addr  (uword.read_addr),
        .write_addr (spad_waddr),
        .write_en   (spad_wen),
        .write_data (wdata),
        .read_data  (spad_rdata)
    );

endmodule

// File: dct_ref_model.svh
// Expected outputs of the 8-point DCT, computed stage by stage from the flow graph.
// Products are Q8, shifted right arithmetically by 8, and every sum wraps at 16 bits.
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// a times a Q8 constant, wrapped back to 16 bits
function automatic dct_pkg::data_t scaled_product(input dct_pkg::data_t a, input int c);
    logic signed [31:0] p;
    p = a * c;
    return p[23:8];
endfunction

function automatic void expected_coeffs(input dct_pkg::data_t x [8],
                                        output dct_pkg::data_t y [8]);
    dct_pkg::data_t s [24];
    s[0] = x[0] + x[7];
    s[1] = x[1] + x[6];
    s[2] = x[2] + x[5];
    s[3] = x[3] + x[4];
    s[4] = x[3] - x[4];
    s[5] = x[2] - x[5];
    s[6] = x[1] - x[6];
    s[7] = x[0] - x[7];
    s[8]  = s[0] + s[3];
    s[9]  = s[1] + s[2];
    s[10] = s[1] - s[2];
    s[11] = s[0] - s[3];
    y[0] = scaled_product(s[8], 91) + scaled_product(s[9], 91);     // sqrt2/4
    y[4] = scaled_product(s[8], 91) - scaled_product(s[9], 91);
    y[2] = scaled_product(s[10], 139) + scaled_product(s[11], 334);
    y[6] = scaled_product(s[11], 139) - scaled_product(s[10], 334);
    // odd rotations by 3pi/16 and pi/16
    s[12] = scaled_product(s[4], 213) + scaled_product(s[7], 142);
    s[15] = scaled_product(s[7], 213) - scaled_product(s[4], 142);
    s[13] = scaled_product(s[5], 251) + scaled_product(s[6], 50);
    s[14] = scaled_product(s[6], 251) - scaled_product(s[5], 50);
    s[20] = s[12] + s[14];
    s[21] = s[15] - s[13];
    s[22] = s[12] - s[14];
    s[23] = s[15] + s[13];
    y[1] = s[20] + s[23];
    y[7] = s[23] - s[20];
    y[3] = scaled_product(s[21], 362);   // sqrt2
    y[5] = scaled_product(s[22], 362);
endfunction

`endif

// File: tb_loeffler_dct8.sv
// Testbench for the microcoded 8-point DCT: result values, index order and done latency.
// Samples stay in -128..127, and the input buffer answers one cycle after the address.
module tb_loeffler_dct8;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TRANSFORMS    = 23;
    localparam int WATCHDOG_CYCLES = N_TRANSFORMS * (dct_pkg::UCODE_LEN + 10) + 20;

    logic                      clock;
    logic                      nreset;
    logic                      start;
    logic                      busy;
    logic                      done;
    logic [dct_pkg::IDX_W-1:0] fetch_addr;
    dct_pkg::data_t            fetch_data;
    logic                      result_valid;
    dct_pkg::result_t          result;

    dct_pkg::data_t            block [8];      // input buffer contents
    dct_pkg::data_t            expect_y [8];
    logic [dct_pkg::IDX_W-1:0] addr_q;
    logic [7:0]                seen;           // one bit per output index
    logic                      in_run;
    logic                      started;
    int unsigned               cycle;
    int unsigned               start_cycle;
    int unsigned               done_count;
    string                     test_name;

    `include "dct_ref_model.svh"

    loeffler_dct8 UUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic fail_run(input string line);
        $display("Something failed");
        $display("%s", line);
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string test, input int expected, input int actual);
        fail_run($sformatf("[ERROR] %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    task automatic fill_random();
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r = 8'($urandom());
            block[i] = {{8{r[7]}}, r};   // sign extend
        end
    endtask

    // late_start > 0 pulses a second start that many cycles into the run
    task automatic run_transform(input string name, input int late_start);
        @(negedge clock);
        test_name = name;
        expected_coeffs(block, expect_y);
        start   = 1'b1;
        started = 1'b1;
        @(negedge clock);
        start = 1'b0;
        if (late_start > 0) begin
            repeat (late_start) @(negedge clock);
            start = 1'b1;
            @(negedge clock);
            start = 1'b0;
        end
        do @(posedge clock); while (!done);
    endtask

    // input buffer model
    initial begin
        fetch_data = '0;
        forever begin
            @(posedge clock);
            addr_q = fetch_addr;
            @(negedge clock);
            fetch_data = block[addr_q];
        end
    end

    assert property (@(posedge clock) disable iff (nreset)
                     !started |-> (!busy && !done && !result_valid))
        else fail_run("busy, done or result_valid went high before the first start");

    assert property (@(posedge clock) disable iff (nreset) done |-> (!busy && $past(busy)))
        else fail_run("done did not pulse in the cycle where busy fell");

    always @(posedge clock) begin
        if (nreset) begin
            cycle       = 0;
            start_cycle = 0;
            done_count  = 0;
            seen        = '0;
            in_run      = 1'b0;
        end else begin
            cycle = cycle + 1;
            if (result_valid) begin
                assert (in_run) else fail_run("a result strobe came outside of a transform");
                assert (!seen[result.index])
                    else fail_run($sformatf("%s: index %0d came twice", test_name, result.index));
                assert (result.value == expect_y[result.index])
                    else value_error($sformatf("%s y%0d", test_name, result.index),
                                     int'(expect_y[result.index]), int'(result.value));
                seen[result.index] = 1'b1;
            end
            if (done) begin
                assert (in_run) else fail_run("done pulsed without a running transform");
                assert (cycle - start_cycle == dct_pkg::UCODE_LEN + 1)
                    else value_error({test_name, " done latency"}, dct_pkg::UCODE_LEN + 1,
                                     int'(cycle - start_cycle));
                assert (seen == 8'hff)
                    else fail_run($sformatf("%s: done came before all eight results", test_name));
                in_run     = 1'b0;
                done_count = done_count + 1;
            end
            if (start && !busy) begin   // accepted start
                start_cycle = cycle;
                in_run      = 1'b1;
                seen        = '0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        fail_run("watchdog timeout, a transform never signalled done");
    end

    initial begin
        void'($urandom(86));
        nreset    = 1'b1;
        start     = 1'b0;
        started   = 1'b0;
        test_name = "reset";
        for (int i = 0; i < 8; i++) block[i] = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        nreset = 1'b0;
        repeat (5) @(negedge clock);    // idle outputs are watched meanwhile
        run_transform("zero block", 0);
        for (int i = 0; i < 8; i++) block[i] = 16'sd100;
        run_transform("constant block", 0);
        for (int t = 0; t < 20; t++) begin
            fill_random();
            run_transform($sformatf("random block %0d", t), 0);
        end
        fill_random();
        run_transform("start while busy", 10);
        repeat (2) @(negedge clock);
        assert (!busy) else fail_run("a start while busy launched a second transform");
        if (done_count == N_TRANSFORMS) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run($sformatf("only %0d of %0d transforms finished", done_count, N_TRANSFORMS));
        end
    end

endmodule

// File: verilog.f
+incdir+.
dct_pkg.sv
dct_multiplier.sv
dct_scratchpad.sv
dct_sequencer.sv
dct_datapath.sv
loeffler_dct8.sv
tb_loeffler_dct8.sv

// File: run.sh
#!/bin/sh
# builds and runs the DCT testbench with Verilator, result is taken from sim.log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_loeffler_dct8 -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log
if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
